// ==== include/sound_defines.svh ====
// widths and depth for the sample path; FIFO_DEPTH must be at least 2, gains are unsigned 4.4
`ifndef SOUND_DEFINES_SVH
`define SOUND_DEFINES_SVH

// sample ROM byte address, wraps at the top
`define ROM_AW 18

// pcm sample after conversion, byte sits in the top 8 bits
`define PCM_W 14

// one FM channel word
`define FM_W 16

// mixer output per side
`define OUT_W 16

// gain format 4.4, so 0x10 is unity
`define GAIN_FRAC 4

// entries per stream FIFO
`define FIFO_DEPTH 8

`endif

// ==== logic/sound_pkg.sv ====
// payload types for the sample path; burst count is fixed at 16 bits, all samples two's complement
`include "sound_defines.svh"

package sound_pkg;

    // stereo frame from the FM synth
    typedef struct packed {
        logic signed [`FM_W-1:0] left;
        logic signed [`FM_W-1:0] right;
    } fm_frame_t;

    // converted pcm sample, (byte - 128) << 6
    typedef logic signed [`PCM_W-1:0] pcm_sample_t;

    // one burst request
    typedef struct packed {
        logic [`ROM_AW-1:0] start;  // first byte address
        logic [15:0]        count;  // bytes, 0 allowed
    } pcm_cmd_t;

    // both gains unsigned 4.4
    typedef struct packed {
        logic [7:0] fm_gain;
        logic [7:0] pcm_gain;
    } gain_set_t;

    // mixer result
    typedef struct packed {
        logic signed [`OUT_W-1:0] left;
        logic signed [`OUT_W-1:0] right;
        logic                     peak;   // either side clamped
    } mix_out_t;

endpackage

// ==== logic/pcm_fetch.sv ====
// one burst at a time, one ROM read in flight; cmd and rom_data must obey valid/ok as described
`timescale 1ns/1ps
`include "sound_defines.svh"

module pcm_fetch (
    input  logic                   CLK,
    input  logic                   reset,
    input  sound_pkg::pcm_cmd_t    cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    output logic                   rom_cs,
    output logic [`ROM_AW-1:0]     rom_addr,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok,
    output sound_pkg::pcm_sample_t smp,
    output logic                   smp_valid,
    input  logic                   smp_ready,
    output logic                   busy
);
    typedef enum logic [1:0] {
        st_idle,    // waiting for a command
        st_rom,     // cs up, waiting on rom_ok
        st_offer    // sample held for the FIFO
    } state_t;

    state_t                 state;
    logic [`ROM_AW-1:0]     addr;       // current byte address
    logic [15:0]            remaining;  // bytes left incl. current
    sound_pkg::pcm_sample_t smp_q;
    logic                   smp_done;

    assign smp_done  = (state == st_offer) && smp_ready;

    assign cmd_ready = (state == st_idle);
    assign busy      = (state != st_idle);  // rises the cycle after accept
    assign rom_cs    = (state == st_rom);
    assign rom_addr  = addr;                // steady for the whole request
    assign smp_valid = (state == st_offer);
    assign smp       = smp_q;

    always_ff @(posedge CLK) begin
        if (reset) begin
            state     <= st_idle;
            addr      <= '0;
            remaining <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (cmd_valid) begin
                        addr      <= cmd.start;
                        remaining <= cmd.count;
                        // zero count: accepted, nothing to fetch
                        if (cmd.count != '0) state <= st_rom;
                    end
                end
                st_rom: begin
                    if (rom_ok) state <= st_offer;  // cs drops next cycle
                end
                st_offer: begin
                    if (smp_done) begin
                        if (remaining == 16'd1) begin
                            state <= st_idle;       // burst finished
                        end else begin
                            remaining <= remaining - 16'd1;
                            addr      <= addr + 1'b1;   // wraps mod 2^ROM_AW
                            state     <= st_rom;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // unsigned byte to signed: flip msb, then scale up to PCM_W
    always_ff @(posedge CLK) begin
        if (state == st_rom && rom_ok) begin
            smp_q <= {rom_data ^ 8'h80, {(`PCM_W-8){1'b0}}};
        end
    end

endmodule

// ==== logic/sample_fifo.sv ====
// single clock FIFO, no read latency; input opens one cycle after reset, push+pop allowed when full
`timescale 1ns/1ps
`include "sound_defines.svh"

module sample_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = `FIFO_DEPTH
) (
    input  logic CLK,
    input  logic reset,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] count;       // occupancy
    logic          armed;       // low during reset
    logic          push, pop;

    function automatic logic [AW-1:0] bump(input logic [AW-1:0] p);
        if (p == AW'(DEPTH - 1)) return '0;   // wrap, DEPTH need not be 2^n
        return p + 1'b1;
    endfunction

    assign out_valid = (count != '0);
    // full still takes a push when the head leaves this cycle
    assign in_ready  = armed && ((count != CW'(DEPTH)) || out_ready);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge CLK) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            armed  <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (push) wr_ptr <= bump(wr_ptr);
            if (pop)  rd_ptr <= bump(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge CLK) begin
        if (push) mem[wr_ptr] <= in_data;
    end

endmodule

// ==== logic/gain_mixer.sv ====
// pairs one FM frame with one pcm sample; gains are read at take time and must be steady meanwhile
`timescale 1ns/1ps
`include "sound_defines.svh"

module gain_mixer (
    input  logic                   CLK,
    input  logic                   reset,
    input  logic                   pause,
    input  sound_pkg::gain_set_t   gains,
    input  sound_pkg::fm_frame_t   fm,
    input  logic                   fm_valid,
    output logic                   fm_ready,
    input  sound_pkg::pcm_sample_t pcm,
    input  logic                   pcm_valid,
    output logic                   pcm_ready,
    output sound_pkg::mix_out_t    mix,
    output logic                   mix_valid,
    input  logic                   mix_ready
);
    localparam int ACC_W = `FM_W + 10;  // 16x9 product plus one carry

    logic                    take;
    logic signed [8:0]       fm_g, pcm_g;   // gains, zero extended
    logic signed [ACC_W-1:0] acc_l, acc_r;
    logic [`OUT_W:0]         sat_l, sat_r;  // {clipped, value}
    sound_pkg::mix_out_t     mix_q;
    logic                    mix_valid_q;

    // shift out the fraction, then clamp to OUT_W
    function automatic logic [`OUT_W:0] clamp(input logic signed [ACC_W-1:0] acc);
        logic signed [ACC_W-1:0] s;
        logic [ACC_W-`OUT_W:0]   top;
        s   = acc >>> `GAIN_FRAC;
        top = s[ACC_W-1:`OUT_W-1];     // must be all sign bits to fit
        if (&top || ~|top) begin
            return {1'b0, s[`OUT_W-1:0]};
        end else if (s[ACC_W-1]) begin
            return {1'b1, 1'b1, {(`OUT_W-1){1'b0}}};  // -32768
        end else begin
            return {1'b1, 1'b0, {(`OUT_W-1){1'b1}}};  // 32767
        end
    endfunction

    // both inputs present, not paused, output slot free or leaving
    assign take      = fm_valid && pcm_valid && !pause && (!mix_valid_q || mix_ready);
    assign fm_ready  = take;
    assign pcm_ready = take;    // both streams advance together

    assign fm_g  = {1'b0, gains.fm_gain};
    assign pcm_g = {1'b0, gains.pcm_gain};

    assign acc_l = fm.left * fm_g + pcm * pcm_g;
    assign acc_r = fm.right * fm_g + pcm * pcm_g;
    assign sat_l = clamp(acc_l);
    assign sat_r = clamp(acc_r);

    // output slot valid
    always_ff @(posedge CLK) begin
        if (reset) begin
            mix_valid_q <= 1'b0;
        end else if (take) begin
            mix_valid_q <= 1'b1;    // refill in the drain cycle
        end else if (mix_ready) begin
            mix_valid_q <= 1'b0;
        end
    end

    // result register, held under back-pressure and pause
    always_ff @(posedge CLK) begin
        if (take) begin
            mix_q.left  <= sat_l[`OUT_W-1:0];
            mix_q.right <= sat_r[`OUT_W-1:0];
            mix_q.peak  <= sat_l[`OUT_W] | sat_r[`OUT_W];
        end
    end

    assign mix       = mix_q;
    assign mix_valid = mix_valid_q;

endmodule

// ==== logic/sound_top.sv ====
// fetch, two stream FIFOs and mixer on one clock; gains held steady while pairs are in flight
`timescale 1ns/1ps
`include "sound_defines.svh"

module sound_top (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 pause,
    input  sound_pkg::gain_set_t gains,
    input  sound_pkg::pcm_cmd_t  cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    output logic                 busy,
    output logic                 rom_cs,
    output logic [`ROM_AW-1:0]   rom_addr,
    input  logic [7:0]           rom_data,
    input  logic                 rom_ok,
    input  sound_pkg::fm_frame_t fm_in,
    input  logic                 fm_in_valid,
    output logic                 fm_in_ready,
    output sound_pkg::mix_out_t  mix,
    output logic                 mix_valid,
    input  logic                 mix_ready
);
    // fetch to pcm FIFO
    sound_pkg::pcm_sample_t smp;
    logic                   smp_valid, smp_ready;
    // FIFO heads to mixer
    sound_pkg::pcm_sample_t pcm_q;
    logic                   pcm_q_valid, pcm_q_ready;
    sound_pkg::fm_frame_t   fm_q;
    logic                   fm_q_valid, fm_q_ready;

    pcm_fetch u_fetch (
        .CLK       (CLK),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .smp       (smp),
        .smp_valid (smp_valid),
        .smp_ready (smp_ready),
        .busy      (busy)
    );

    sample_fifo #(.T(sound_pkg::pcm_sample_t), .DEPTH(`FIFO_DEPTH)) u_pcm_fifo (
        .CLK       (CLK),
        .reset     (reset),
        .in_data   (smp),
        .in_valid  (smp_valid),
        .in_ready  (smp_ready),
        .out_data  (pcm_q),
        .out_valid (pcm_q_valid),
        .out_ready (pcm_q_ready)
    );

    sample_fifo #(.T(sound_pkg::fm_frame_t), .DEPTH(`FIFO_DEPTH)) u_fm_fifo (
        .CLK       (CLK),
        .reset     (reset),
        .in_data   (fm_in),
        .in_valid  (fm_in_valid),
        .in_ready  (fm_in_ready),   // low through reset
        .out_data  (fm_q),
        .out_valid (fm_q_valid),
        .out_ready (fm_q_ready)
    );

    gain_mixer u_mixer (
        .CLK       (CLK),
        .reset     (reset),
        .pause     (pause),
        .gains     (gains),
        .fm        (fm_q),
        .fm_valid  (fm_q_valid),
        .fm_ready  (fm_q_ready),
        .pcm       (pcm_q),
        .pcm_valid (pcm_q_valid),
        .pcm_ready (pcm_q_ready),
        .mix       (mix),
        .mix_valid (mix_valid),
        .mix_ready (mix_ready)
    );

endmodule

// ==== verif/sound_assert.sv ====
// handshake checks bound into sound_top; stability rules are off while reset is high
`timescale 1ns/1ps
`include "sound_defines.svh"

module sound_assert (
    input logic                 CLK,
    input logic                 reset,
    input logic                 cmd_ready,
    input logic                 busy,
    input logic                 rom_cs,
    input logic [`ROM_AW-1:0]   rom_addr,
    input logic                 rom_ok,
    input sound_pkg::fm_frame_t fm_in,
    input logic                 fm_in_valid,
    input logic                 fm_in_ready,
    input sound_pkg::mix_out_t  mix,
    input logic                 mix_valid,
    input logic                 mix_ready
);
    // output held while the sink stalls
    mix_hold: assert property (@(posedge CLK) disable iff (reset)
        mix_valid && !mix_ready |=> mix_valid && $stable(mix))
        else $error("mix dropped or changed under back-pressure");

    fm_hold: assert property (@(posedge CLK) disable iff (reset)
        fm_in_valid && !fm_in_ready |=> fm_in_valid && $stable(fm_in))
        else $error("fm_in dropped or changed while not ready");

    // request and address steady until ok
    rom_hold: assert property (@(posedge CLK) disable iff (reset)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else $error("rom request dropped or address moved before ok");

    // state is known from the first reset edge on
    rom_quiet: assert property (@(posedge CLK) reset && $past(reset) |-> !rom_cs)
        else $error("rom_cs high during reset");

    idle_not_busy: assert property (@(posedge CLK) disable iff (reset) cmd_ready |-> !busy)
        else $error("busy high while cmd_ready is high");

endmodule

bind sound_top sound_assert u_assert (
    .CLK         (CLK),
    .reset       (reset),
    .cmd_ready   (cmd_ready),
    .busy        (busy),
    .rom_cs      (rom_cs),
    .rom_addr    (rom_addr),
    .rom_ok      (rom_ok),
    .fm_in       (fm_in),
    .fm_in_valid (fm_in_valid),
    .fm_in_ready (fm_in_ready),
    .mix         (mix),
    .mix_valid   (mix_valid),
    .mix_ready   (mix_ready)
);

// ==== verif/sound_tb.sv ====
// directed tests for sound_top; ROM model waits 0..3 cycles and returns addr[7:0]^0x5A
`timescale 1ns/1ps
`include "sound_defines.svh"

module sound_tb;
    localparam int TIMEOUT = 4000;          // cycles, well above all tests together

    logic                 CLK = 1'b0;
    logic                 reset, pause, cmd_valid, bp_on;
    logic                 rom_ok = 1'b0;
    logic                 fm_in_valid = 1'b0;
    logic                 mix_ready = 1'b0;
    logic [7:0]           rom_data = 8'h00;
    logic                 cmd_ready, busy, rom_cs, fm_in_ready, mix_valid;
    logic [`ROM_AW-1:0]   rom_addr;
    sound_pkg::gain_set_t gains;
    sound_pkg::pcm_cmd_t  cmd;
    sound_pkg::fm_frame_t fm_in = '0;
    sound_pkg::mix_out_t  mix, mon_exp;
    sound_pkg::fm_frame_t fm_src[$];        // frames not yet offered to the DUT
    sound_pkg::mix_out_t  exp_q[$];         // expected outputs in order
    logic [`ROM_AW-1:0]   addr_exp_q[$];    // expected ROM read addresses in order
    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int peaks  = 0;
    int cycles = 0;
    int rom_wait;

    sound_top uut (.*);

    always #2 CLK = ~CLK;                   // 4 ns period

    // sample ROM, random wait states per request
    always @(posedge CLK) begin
        if (reset) begin
            rom_ok   <= 1'b0;
            rom_wait <= 0;
        end else if (rom_ok) begin
            rom_ok <= 1'b0;                 // ok lasts one cycle
        end else if (rom_cs) begin
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_addr[7:0] ^ 8'h5A;
                rom_wait <= int'($urandom_range(3, 0));  // waits for the next read
                check_rom_addr();
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    // FM source, holds the frame until taken
    always @(posedge CLK) begin
        if (reset) begin
            fm_in_valid <= 1'b0;
        end else if (!fm_in_valid || fm_in_ready) begin
            if (fm_src.size() != 0) begin
                fm_in       <= fm_src.pop_front();
                fm_in_valid <= 1'b1;
            end else begin
                fm_in_valid <= 1'b0;
            end
        end
    end

    always @(posedge CLK) begin
        mix_ready <= bp_on ? 1'($urandom_range(1, 0)) : 1'b1;   // random stalls
    end

    // scoreboard on every output handshake
    always @(posedge CLK) begin
        if (!reset && mix_valid && mix_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("mixer produced an output while none was expected");
            end else begin
                mon_exp = exp_q.pop_front();
                checks++;
                assert (mix === mon_exp) else begin
                    errors++;
                    $display("** Error: mix = %h, expected %h", mix, mon_exp);
                end
                if (mix.peak) peaks++;
            end
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // each answered read must be the next byte of a burst
    task automatic check_rom_addr();
        logic [`ROM_AW-1:0] want;
        if (addr_exp_q.size() == 0) begin
            errors++;
            $display("ROM read at address %h while no read was expected", rom_addr);
        end else begin
            want = addr_exp_q.pop_front();
            checks++;
            assert (rom_addr === want) else begin
                errors++;
                $display("** Error: rom_addr = %h, expected %h", rom_addr, want);
            end
        end
    endtask

    // ROM byte for an address, then (byte - 128) << 6
    function automatic int pcm_of(input logic [`ROM_AW-1:0] a);
        int b;
        b = int'(a[7:0] ^ 8'h5A);
        return (b - 128) * 64;
    endfunction

    function automatic int clip(input int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    // expected result from the mix rule, integer math
    function automatic sound_pkg::mix_out_t mix_rule(input sound_pkg::fm_frame_t f, input int p);
        int l, r, pg, fg;
        sound_pkg::mix_out_t m;
        fg = int'(gains.fm_gain);
        pg = int'(gains.pcm_gain);
        l = (int'($signed(f.left)) * fg + p * pg) >>> `GAIN_FRAC;
        r = (int'($signed(f.right)) * fg + p * pg) >>> `GAIN_FRAC;
        m.left  = 16'(clip(l));
        m.right = 16'(clip(r));
        m.peak  = (clip(l) != l) || (clip(r) != r);  // either side clamped
        return m;
    endfunction

    task automatic check_bit(input string name, input logic act, input logic want);
        checks++;
        assert (act === want) else begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, act, want);
        end
    endtask

    task automatic set_gains(input logic [7:0] fm_g, input logic [7:0] pcm_g);
        @(posedge CLK);
        gains <= '{fm_gain: fm_g, pcm_gain: pcm_g};
        @(posedge CLK);                     // settled before expected values use it
    endtask

    task automatic send_cmd(input logic [`ROM_AW-1:0] start, input int n);
        @(posedge CLK);
        cmd       <= '{start: start, count: 16'(n)};
        cmd_valid <= 1'b1;
        do @(posedge CLK); while (!cmd_ready);  // taken on this edge
        cmd_valid <= 1'b0;
    endtask

    // n frames in +-amp, their expected results, then the burst
    task automatic queue_burst(input logic [`ROM_AW-1:0] start, input int n, input int amp);
        sound_pkg::fm_frame_t f;
        logic [`ROM_AW-1:0]   a;
        for (int k = 0; k < n; k++) begin
            a = start + `ROM_AW'(k);        // address wraps
            f.left  = 16'(int'($urandom_range(2 * amp, 0)) - amp);
            f.right = 16'(int'($urandom_range(2 * amp, 0)) - amp);
            fm_src.push_back(f);
            addr_exp_q.push_back(a);
            exp_q.push_back(mix_rule(f, pcm_of(a)));
        end
        send_cmd(start, n);
    endtask

    task automatic wait_drain();
        do @(posedge CLK); while (exp_q.size() != 0 || busy || fm_in_valid);
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        if (errors == err0) $display("%-12s ok", name);
        else $display("%-12s %0d errors", name, errors - err0);
    endtask

    // outputs while reset is still applied
    task automatic test_reset_state();
        int e0;
        e0 = errors;
        check_bit("mix_valid", mix_valid, 1'b0);
        check_bit("rom_cs", rom_cs, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("fm_in_ready", fm_in_ready, 1'b0);
        check_bit("cmd_ready", cmd_ready, 1'b1);
        end_test("reset_state", e0);
    endtask

    task automatic test_basic();
        int e0;
        e0 = errors;
        set_gains(8'h10, 8'h10);            // unity
        queue_burst(18'h00100, 4, 2000);    // small enough that nothing clips
        wait_drain();
        end_test("basic_mix", e0);
    endtask

    task automatic test_saturation();
        int e0, p0;
        e0 = errors;
        p0 = peaks;
        set_gains(8'h40, 8'h40);            // x4 on both
        queue_burst(18'h00200, 8, 32767);
        wait_drain();
        check_bit("peak", peaks > p0, 1'b1);
        end_test("saturation", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        e0 = errors;
        set_gains(8'h10, 8'h18);
        bp_on <= 1'b1;
        queue_burst(18'h01000, 16, 12000);  // twice the FIFO depth
        wait_drain();
        bp_on <= 1'b0;
        end_test("backpressure", e0);
    endtask

    task automatic test_wrap();
        int e0;
        e0 = errors;
        queue_burst(18'h3FFFA, 12, 4000);   // crosses 0x3FFFF to 0
        do @(posedge CLK); while (busy);
        check_bit("cmd_ready", cmd_ready, 1'b1);
        check_bit("rom_cs", rom_cs, 1'b0);
        wait_drain();
        end_test("rom_wrap", e0);
    endtask

    task automatic test_pause();
        int e0;
        e0 = errors;
        pause <= 1'b1;
        queue_burst(18'h02000, 6, 3000);    // fits both FIFOs
        do begin
            @(posedge CLK);
            check_bit("mix_valid", mix_valid, 1'b0);
        end while (busy || fm_in_valid);
        pause <= 1'b0;
        wait_drain();
        end_test("pause", e0);
    endtask

    // last test, its FM frames stay unpaired in the FIFO
    task automatic test_zero_len();
        int e0;
        e0 = errors;
        send_cmd(18'h00300, 0);
        @(posedge CLK);
        check_bit("busy", busy, 1'b0);
        check_bit("cmd_ready", cmd_ready, 1'b1);
        repeat (3) fm_src.push_back(sound_pkg::fm_frame_t'{left: 16'sd1000, right: -16'sd1000});
        repeat (30) begin
            @(posedge CLK);
            check_bit("mix_valid", mix_valid, 1'b0);
            check_bit("rom_cs", rom_cs, 1'b0);
        end
        end_test("zero_length", e0);
    endtask

    initial begin
        void'($urandom(64063));             // one seed for the run
        reset     <= 1'b1;
        pause     <= 1'b0;
        cmd_valid <= 1'b0;
        cmd       <= '0;
        gains     <= '0;
        bp_on     <= 1'b0;
        repeat (2) @(posedge CLK);
        test_reset_state();
        reset <= 1'b0;
        test_basic();
        test_saturation();
        test_backpressure();
        test_wrap();
        test_pause();
        test_zero_len();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
logic/sound_pkg.sv
logic/pcm_fetch.sv
logic/sample_fifo.sv
logic/gain_mixer.sv
logic/sound_top.sv
verif/sound_assert.sv
verif/sound_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the sample path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module sound_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out="$(./obj_dir/Vsound_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
echo "pass message not found"
exit 1
